//--- Makefile
TOOL     := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := rxrst_tb
FILELIST := all.f
OBJ_DIR  := obj_dir
LOG      := sim.log
PASS_MSG := ALL CHECKS PASSED

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "result: pass"; \
	else \
		echo "result: fail, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- all.f
+incdir+common
common/rxrst_pkg.sv
common/rx_status_if.sv
source/rxrst_debounce.sv
source/rx_status_cond.sv
rxlane_fsm/rxlane_rst_fsm.sv
source/rxrst_top.sv
dv/rxrst_sva.sv
dv/rxrst_tb.sv

//--- common/rx_status_if.sv
//////////////////////////////////////////////////
// Conditioned status of one receive lane
// Plain levels, valid on every clk edge, no
// handshake
//////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

interface rx_status_if;

    logic pll_lock;   // Debounced PLL lock
    logic sigdet;     // Debounced signal detect
    logic cdr_ready;  // Debounced CDR ready
    logic word_sync;  // Synchronized word alignment, no debounce

    // Status conditioner side
    modport producer (
        output pll_lock,
        output sigdet,
        output cdr_ready,
        output word_sync
    );

    // Lane state machine side
    modport consumer (
        input  pll_lock,
        input  sigdet,
        input  cdr_ready,
        input  word_sync
    );

endinterface

`default_nettype wire

//--- common/rxrst_cfg.svh
//////////////////////////////////////////////////
// Build-time settings of the RX reset sequencer
// All counts are in cycles of the free-running clk
// Debounce and timer values must fit RXRST_CNT_W
// bits and must each be at least 1
// The values here are small, for fast simulation
//////////////////////////////////////////////////
`ifndef RXRST_CFG_SVH
`define RXRST_CFG_SVH

// Lane count and synchronizer depth
`define RXRST_NUM_LANES       4
`define RXRST_SYNC_STAGES     2

// Rise debounce counts for the PHY status inputs
`define RXRST_SIGDET_DEB      4
`define RXRST_CDR_DEB         16
`define RXRST_PLL_DEB         16

// Lane sequencing timers
`define RXRST_PMA_RST_CYCLES  8   // PMA reset pulse width
`define RXRST_ALIGN_TIMER     64  // Word alignment budget before retry

// Width of every timer and debounce counter
`define RXRST_CNT_W           12

`endif

//--- common/rxrst_pkg.sv
//////////////////////////////////////////////////
// Types shared by the RX lane reset logic
// Counter width follows RXRST_CNT_W from the
// configuration header
//////////////////////////////////////////////////
`default_nettype none

`include "rxrst_cfg.svh"

package rxrst_pkg;

    ////////////////////////////////////////////////
    // Lane reset sequence states
    ////////////////////////////////////////////////
    typedef enum logic [2:0] {
        ST_LANE_PD     = 3'd0,  // Lane powered down, waiting for PLL lock
        ST_PMA_RST     = 3'd1,  // PMA reset pulse
        ST_WAIT_SIGDET = 3'd2,  // Waiting for signal detect
        ST_WAIT_CDR    = 3'd3,  // Waiting for CDR lock
        ST_PCS_RST     = 3'd4,  // Single cycle before PCS reset release
        ST_WAIT_ALIGN  = 3'd5,  // Waiting for word alignment
        ST_DONE        = 3'd6   // Lane up
    } rx_state_e;

    // Timer and debounce counter
    typedef logic [`RXRST_CNT_W-1:0] rxrst_cnt_t;

endpackage

`default_nettype wire

//--- dv/rxrst_sva.sv
//////////////////////////////////////////////////
// Lane FSM assertions, bound into every
// rxlane_rst_fsm instance
// All checks are off while the lane is in reset
//////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

`include "rxrst_cfg.svh"

module rxrst_sva
    import rxrst_pkg::*;
(
    input wire       clk,
    input wire       i_rst,
    input rx_state_e state_q,
    input wire       o_lane_pd,
    input wire       o_pma_rst,
    input wire       o_pcs_rst,
    input wire       o_lane_done
);

    localparam int PMA_CYC = `RXRST_PMA_RST_CYCLES;

    logic in_pma;

    assign in_pma = (state_q == ST_PMA_RST);

    // Registered outputs always match the current state
    a_out_map: assert property (@(posedge clk) disable iff (i_rst)
        (o_lane_pd == (state_q == ST_LANE_PD)) &&
        (o_pma_rst == (state_q inside {ST_LANE_PD, ST_PMA_RST})) &&
        (o_pcs_rst == (state_q inside {ST_LANE_PD, ST_PMA_RST, ST_WAIT_SIGDET,
                                       ST_WAIT_CDR, ST_PCS_RST})) &&
        (o_lane_done == (state_q == ST_DONE)))
        else $error("lane outputs do not match state %0d", state_q);

    a_done_no_rst: assert property (@(posedge clk) disable iff (i_rst)
        o_lane_done |-> (!o_pma_rst && !o_pcs_rst))
        else $error("lane done while PMA or PCS reset is active");

    // A PLL loss ends the pulse early through ST_LANE_PD
    a_pma_width: assert property (@(posedge clk) disable iff (i_rst || state_q == ST_LANE_PD)
        $rose(in_pma) |-> ##(PMA_CYC - 1) in_pma ##1 !in_pma)
        else $error("PMA reset state did not last %0d cycles", PMA_CYC);

endmodule

`default_nettype wire

//--- dv/rxrst_tb.sv
//////////////////////////////////////////////////
// Directed testbench for the RX reset sequencer
// PHY status is modeled as levels driven on the
// falling clk edge, outputs are sampled there too
// Every wait is bounded by its own cycle limit
//////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

`include "rxrst_cfg.svh"

module rxrst_tb;

    localparam int NL          = `RXRST_NUM_LANES;
    localparam int DONE_LIMIT  = 60;
    localparam int LOSS_LIMIT  = 10;
    localparam int ALIGN_LIMIT = `RXRST_ALIGN_TIMER + 20;
    localparam int FILTER_CYC  = 200;

    logic          clk;
    logic          i_rst;
    logic [NL-1:0] i_lane_rst;
    logic [NL-1:0] i_pll_lock;
    logic [NL-1:0] i_sigdet;
    logic [NL-1:0] i_cdr_ready;
    logic [NL-1:0] i_word_sync;
    logic [NL-1:0] o_lane_pd;
    logic [NL-1:0] o_pma_rst;
    logic [NL-1:0] o_pcs_rst;
    logic [NL-1:0] o_lane_done;

    int    seed;
    int    tests;
    int    checks;
    int    errors;
    int    test_errors;
    string test_name;

    rxrst_top rxrst_top_i (
        .clk         (clk),
        .i_rst       (i_rst),
        .i_lane_rst  (i_lane_rst),
        .i_pll_lock  (i_pll_lock),
        .i_sigdet    (i_sigdet),
        .i_cdr_ready (i_cdr_ready),
        .i_word_sync (i_word_sync),
        .o_lane_pd   (o_lane_pd),
        .o_pma_rst   (o_pma_rst),
        .o_pcs_rst   (o_pcs_rst),
        .o_lane_done (o_lane_done)
    );

    bind rxlane_rst_fsm rxrst_sva rxlane_sva (
        .clk         (clk),
        .i_rst       (i_rst),
        .state_q     (state_q),
        .o_lane_pd   (o_lane_pd),
        .o_pma_rst   (o_pma_rst),
        .o_pcs_rst   (o_pcs_rst),
        .o_lane_done (o_lane_done)
    );

    always #4 clk = ~clk;  // 8 ns period

    //////////////////////////////////////////////////
    // Checks and bounded waits
    //////////////////////////////////////////////////
    task automatic expect_bit(input string what, input logic expected, input logic actual);
        checks++;
        assert (actual === expected) else begin
            test_errors++;
            $display("** Error [%s] %s: expected %0b, actual %0b",
                     test_name, what, expected, actual);
        end
    endtask

    task automatic verify(input logic cond, input string text);
        checks++;
        assert (cond) else begin
            test_errors++;
            $display("** Error [%s] %s", test_name, text);
        end
    endtask

    task automatic check_reset_values(input int lane);
        expect_bit($sformatf("o_lane_pd[%0d]", lane), 1'b1, o_lane_pd[lane]);
        expect_bit($sformatf("o_pma_rst[%0d]", lane), 1'b1, o_pma_rst[lane]);
        expect_bit($sformatf("o_pcs_rst[%0d]", lane), 1'b1, o_pcs_rst[lane]);
        expect_bit($sformatf("o_lane_done[%0d]", lane), 1'b0, o_lane_done[lane]);
    endtask

    function automatic logic out_bit(input string name, input int lane);
        if (name == "o_lane_pd") return o_lane_pd[lane];
        if (name == "o_pma_rst") return o_pma_rst[lane];
        if (name == "o_pcs_rst") return o_pcs_rst[lane];
        return o_lane_done[lane];
    endfunction

    task automatic wait_output(input string name, input int lane, input logic level,
                               input int limit);
        int   cyc;
        logic seen;
        cyc  = 0;
        seen = (out_bit(name, lane) == level);
        while (!seen && cyc < limit) begin
            @(negedge clk);
            cyc++;
            seen = (out_bit(name, lane) == level);
        end
        verify(seen, $sformatf("timeout: %s[%0d] did not go to %0b within %0d cycles",
                               name, lane, level, limit));
    endtask

    function automatic int pick_lane();
        return $unsigned($random(seed)) % NL;
    endfunction

    task automatic start_test(input string name);
        test_name   = name;
        test_errors = 0;
        tests++;
    endtask

    task automatic end_test();
        errors += test_errors;
        $display("%-16s %s, %0d errors", test_name, (test_errors == 0) ? "pass" : "fail",
                 test_errors);
    endtask

    // One signal detect level for len cycles, flags any cycle where the lane moved on
    task automatic hold_sigdet(input int lane, input logic level, input int len,
                               inout int cyc, inout logic leaked);
        i_sigdet[lane] = level;
        repeat (len) begin
            @(negedge clk);
            cyc++;
            leaked = leaked | !o_pcs_rst[lane] | o_lane_done[lane];
        end
    endtask

    //////////////////////////////////////////////////
    // Tests
    //////////////////////////////////////////////////
    task automatic reset_state();
        start_test("reset_state");
        repeat (16) @(negedge clk);  // Still inside the reset window
        for (int l = 0; l < NL; l++) begin
            check_reset_values(l);
        end
        i_rst = 1'b0;
        @(negedge clk);  // Status inputs still low
        for (int l = 0; l < NL; l++) begin
            check_reset_values(l);
        end
        end_test();
    endtask

    task automatic bring_up();
        int pma_at [NL];
        int pcs_at [NL];
        int cyc;
        start_test("bring_up");
        for (int l = 0; l < NL; l++) begin
            pma_at[l] = -1;
            pcs_at[l] = -1;
        end
        i_pll_lock  = '1;
        i_sigdet    = '1;
        i_cdr_ready = '1;
        i_word_sync = '1;
        cyc = 0;
        while (o_lane_done != '1 && cyc < DONE_LIMIT) begin
            @(negedge clk);
            cyc++;
            for (int l = 0; l < NL; l++) begin
                if (pma_at[l] < 0 && !o_pma_rst[l]) pma_at[l] = cyc;
                if (pcs_at[l] < 0 && !o_pcs_rst[l]) pcs_at[l] = cyc;
            end
        end
        verify(o_lane_done == '1, "timeout: not every lane finished bring-up in 60 cycles");
        for (int l = 0; l < NL; l++) begin
            expect_bit($sformatf("o_lane_pd[%0d]", l), 1'b0, o_lane_pd[l]);
            expect_bit($sformatf("o_pma_rst[%0d]", l), 1'b0, o_pma_rst[l]);
            expect_bit($sformatf("o_pcs_rst[%0d]", l), 1'b0, o_pcs_rst[l]);
            verify(pma_at[l] >= 0 && pma_at[l] < pcs_at[l],
                   $sformatf("lane %0d released PCS reset before PMA reset", l));
        end
        end_test();
    endtask

    task automatic debounce_filter();
        int   lane;
        int   cyc;
        logic leaked;
        start_test("debounce_filter");
        lane = pick_lane();
        i_sigdet[lane] = 1'b0;  // Knock the lane back to PMA reset first
        wait_output("o_pcs_rst", lane, 1'b1, LOSS_LIMIT);
        cyc    = 0;
        leaked = 1'b0;
        while (cyc < FILTER_CYC) begin
            hold_sigdet(lane, 1'b1, 1 + $unsigned($random(seed)) % (`RXRST_SIGDET_DEB - 1),
                        cyc, leaked);
            hold_sigdet(lane, 1'b0, 1 + $unsigned($random(seed)) % 4, cyc, leaked);
        end
        expect_bit($sformatf("lane %0d left reset on glitches", lane), 1'b0, leaked);
        i_sigdet[lane] = 1'b1;
        wait_output("o_lane_done", lane, 1'b1, DONE_LIMIT);
        end_test();
    endtask

    task automatic align_timeout();
        int   lane;
        int   cyc;
        logic retried;
        logic done_seen;
        start_test("align_timeout");
        lane = pick_lane();
        i_word_sync[lane] = 1'b0;
        wait_output("o_lane_done", lane, 1'b0, LOSS_LIMIT);
        wait_output("o_pcs_rst", lane, 1'b0, LOSS_LIMIT);  // Now in ST_WAIT_ALIGN
        cyc       = 0;
        retried   = 1'b0;
        done_seen = 1'b0;
        while (!retried && cyc < ALIGN_LIMIT) begin
            @(negedge clk);
            cyc++;
            retried   = o_pma_rst[lane];
            done_seen = done_seen | o_lane_done[lane];
        end
        verify(retried, $sformatf("timeout: lane %0d did not retry PMA reset in %0d cycles",
                                  lane, ALIGN_LIMIT));
        expect_bit("o_lane_done while unaligned", 1'b0, done_seen);
        i_word_sync[lane] = 1'b1;
        wait_output("o_lane_done", lane, 1'b1, DONE_LIMIT);
        end_test();
    endtask

    task automatic loss_recovery();
        int   lane;
        int   cyc;
        logic pma_seen;
        start_test("loss_recovery");
        lane = pick_lane();
        i_pll_lock[lane] = 1'b0;
        wait_output("o_lane_pd", lane, 1'b1, LOSS_LIMIT);
        expect_bit("o_lane_done after PLL loss", 1'b0, o_lane_done[lane]);
        i_pll_lock[lane] = 1'b1;
        wait_output("o_lane_done", lane, 1'b1, DONE_LIMIT);
        i_word_sync[lane] = 1'b0;
        wait_output("o_lane_done", lane, 1'b0, LOSS_LIMIT);
        expect_bit("o_pcs_rst after word sync loss", 1'b1, o_pcs_rst[lane]);
        pma_seen          = o_pma_rst[lane];
        i_word_sync[lane] = 1'b1;
        cyc               = 0;
        while (!o_lane_done[lane] && cyc < DONE_LIMIT) begin
            @(negedge clk);
            cyc++;
            pma_seen = pma_seen | o_pma_rst[lane];
        end
        verify(o_lane_done[lane], "timeout: lane did not realign after word sync returned");
        expect_bit("o_pma_rst during realignment", 1'b0, pma_seen);
        end_test();
    endtask

    task automatic lane_reset();
        int            lane;
        int            cyc;
        logic [NL-1:0] others;
        logic          dropped;
        start_test("lane_reset");
        lane         = pick_lane();
        others       = '1;
        others[lane] = 1'b0;
        i_lane_rst[lane] = 1'b1;
        @(negedge clk);
        i_lane_rst[lane] = 1'b0;
        check_reset_values(lane);
        dropped = ((o_lane_done & others) != others);
        cyc     = 0;
        while (!o_lane_done[lane] && cyc < DONE_LIMIT) begin
            @(negedge clk);
            cyc++;
            dropped = dropped | ((o_lane_done & others) != others);
        end
        verify(o_lane_done[lane], $sformatf("timeout: lane %0d did not finish after reset", lane));
        expect_bit("other lanes lost o_lane_done", 1'b0, dropped);
        end_test();
    endtask

    initial begin
        clk         = 1'b0;
        i_rst       = 1'b1;
        i_lane_rst  = '0;
        i_pll_lock  = '0;
        i_sigdet    = '0;
        i_cdr_ready = '0;
        i_word_sync = '0;
        seed        = 32'h37c9_8011;
        tests       = 0;
        checks      = 0;
        errors      = 0;
        reset_state();
        bring_up();
        debounce_filter();
        align_timeout();
        loss_recovery();
        lane_reset();
        $display("summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- rxlane_fsm/rxlane_rst_fsm.sv
//////////////////////////////////////////////////
// Receive lane reset sequencer
// Powers up the lane, pulses the PMA reset, waits
// for signal detect and CDR lock, then releases
// the PCS reset and waits for word alignment
// Status inputs must already be synchronous
// All four outputs are registered
//////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

`include "rxrst_cfg.svh"

module rxlane_rst_fsm
    import rxrst_pkg::*;
(
    input  wire              clk,
    input  wire              i_rst,
    rx_status_if.consumer    i_status,
    output logic             o_lane_pd,
    output logic             o_pma_rst,
    output logic             o_pcs_rst,
    output logic             o_lane_done
);

    localparam rxrst_cnt_t PMA_LOAD   = rxrst_cnt_t'(`RXRST_PMA_RST_CYCLES - 1);
    localparam rxrst_cnt_t ALIGN_LOAD = rxrst_cnt_t'(`RXRST_ALIGN_TIMER - 1);

    rx_state_e  state_q;
    rx_state_e  state_d;
    rxrst_cnt_t timer_q;    // Shared by PMA reset width and align timeout
    logic       rx_locked;  // Signal detect and CDR both present
    logic       timer_done;

    assign rx_locked  = i_status.sigdet && i_status.cdr_ready;
    assign timer_done = (timer_q == '0);

    //////////////////////////////////////////////////
    // Next state
    //////////////////////////////////////////////////
    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_LANE_PD: begin
                if (i_status.pll_lock) state_d = ST_PMA_RST;
            end
            ST_PMA_RST: begin
                if (timer_done) state_d = ST_WAIT_SIGDET;
            end
            ST_WAIT_SIGDET: begin
                if (i_status.sigdet) state_d = ST_WAIT_CDR;
            end
            ST_WAIT_CDR: begin
                if (!i_status.sigdet) begin
                    state_d = ST_PMA_RST;  // Lost the line while CDR was locking
                end else if (i_status.cdr_ready) begin
                    state_d = ST_PCS_RST;
                end
            end
            ST_PCS_RST: begin
                state_d = rx_locked ? ST_WAIT_ALIGN : ST_PMA_RST;
            end
            ST_WAIT_ALIGN: begin
                if (!rx_locked) begin
                    state_d = ST_PMA_RST;
                end else if (i_status.word_sync) begin
                    state_d = ST_DONE;
                end else if (timer_done) begin
                    state_d = ST_PMA_RST;  // Alignment timed out, retry from PMA
                end
            end
            ST_DONE: begin
                if (!rx_locked) begin
                    state_d = ST_PMA_RST;
                end else if (!i_status.word_sync) begin
                    state_d = ST_PCS_RST;  // Realign only, PMA is still fine
                end
            end
            default: state_d = ST_LANE_PD;
        endcase

        // PLL loss overrides every other rule
        if (state_q != ST_LANE_PD && !i_status.pll_lock) begin
            state_d = ST_LANE_PD;
        end
    end

    //////////////////////////////////////////////////
    // State, timer and outputs
    //////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (i_rst) begin
            state_q <= ST_LANE_PD;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk) begin
        if (i_rst) begin
            timer_q <= '0;
        end else if (state_d != state_q) begin
            // Reload on every state entry
            case (state_d)
                ST_PMA_RST:    timer_q <= PMA_LOAD;
                ST_WAIT_ALIGN: timer_q <= ALIGN_LOAD;
                default:       timer_q <= '0;
            endcase
        end else if (!timer_done) begin
            timer_q <= timer_q - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (i_rst) begin
            o_lane_pd   <= 1'b1;
            o_pma_rst   <= 1'b1;
            o_pcs_rst   <= 1'b1;
            o_lane_done <= 1'b0;
        end else begin
            o_lane_pd   <= (state_d == ST_LANE_PD);
            o_pma_rst   <= (state_d inside {ST_LANE_PD, ST_PMA_RST});
            o_pcs_rst   <= (state_d inside {ST_LANE_PD, ST_PMA_RST, ST_WAIT_SIGDET,
                                            ST_WAIT_CDR, ST_PCS_RST});
            o_lane_done <= (state_d == ST_DONE);
        end
    end

endmodule

`default_nettype wire

//--- source/rx_status_cond.sv
//////////////////////////////////////////////////
// Per-lane status conditioner
// All four PHY inputs are asynchronous and pass
// through RXRST_SYNC_STAGES flops each
// PLL lock, signal detect and CDR ready are also
// rise-debounced, word sync is not
//////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

`include "rxrst_cfg.svh"

module rx_status_cond (
    input  wire              clk,
    input  wire              i_rst,
    input  logic             i_pll_lock,
    input  logic             i_sigdet,
    input  logic             i_cdr_ready,
    input  logic             i_word_sync,
    rx_status_if.producer    o_status
);

    localparam int STAGES = `RXRST_SYNC_STAGES;

    //////////////////////////////////////////////////
    // Synchronizers
    //////////////////////////////////////////////////
    // Bit order {word_sync, cdr_ready, sigdet, pll_lock}
    logic [3:0] sync_q [STAGES];
    logic [3:0] sync_out;

    always_ff @(posedge clk) begin
        if (i_rst) begin
            for (int s = 0; s < STAGES; s++) begin
                sync_q[s] <= '0;
            end
        end else begin
            sync_q[0] <= {i_word_sync, i_cdr_ready, i_sigdet, i_pll_lock};
            for (int s = 1; s < STAGES; s++) begin
                sync_q[s] <= sync_q[s-1];
            end
        end
    end

    assign sync_out = sync_q[STAGES-1];

    //////////////////////////////////////////////////
    // Debouncers
    //////////////////////////////////////////////////
    rxrst_debounce #(
        .RISE_COUNT (`RXRST_PLL_DEB)
    ) pll_lock_deb (
        .clk        (clk),
        .i_rst      (i_rst),
        .i_sig      (sync_out[0]),
        .o_sig_deb  (o_status.pll_lock)
    );

    rxrst_debounce #(
        .RISE_COUNT (`RXRST_SIGDET_DEB)
    ) sigdet_deb (
        .clk        (clk),
        .i_rst      (i_rst),
        .i_sig      (sync_out[1]),
        .o_sig_deb  (o_status.sigdet)
    );

    rxrst_debounce #(
        .RISE_COUNT (`RXRST_CDR_DEB)
    ) cdr_ready_deb (
        .clk        (clk),
        .i_rst      (i_rst),
        .i_sig      (sync_out[2]),
        .o_sig_deb  (o_status.cdr_ready)
    );

    assign o_status.word_sync = sync_out[3];  // Alignment is already stable in the PCS

endmodule

`default_nettype wire

//--- source/rxrst_debounce.sv
//////////////////////////////////////////////////
// Rise-only debouncer
// Output rises after RISE_COUNT consecutive high
// input cycles and falls the cycle after any low
// Input must already be synchronous to clk
//////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

`include "rxrst_cfg.svh"

module rxrst_debounce
    import rxrst_pkg::*;
#(
    parameter int RISE_COUNT = 4  // Must be 1 .. 2**RXRST_CNT_W
) (
    input  wire  clk,
    input  wire  i_rst,
    input  logic i_sig,
    output logic o_sig_deb
);

    localparam rxrst_cnt_t LAST_CNT = rxrst_cnt_t'(RISE_COUNT - 1);

    rxrst_cnt_t high_cnt;  // Consecutive high cycles seen so far

    always_ff @(posedge clk) begin
        if (i_rst || !i_sig) begin
            high_cnt  <= '0;  // Any low cycle restarts the count
            o_sig_deb <= 1'b0;
        end else if (high_cnt == LAST_CNT) begin
            o_sig_deb <= 1'b1;  // Count held here while input stays high
        end else begin
            high_cnt  <= high_cnt + 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- source/rxrst_top.sv
//////////////////////////////////////////////////
// RX reset sequencer, one lane pair per lane bit
// PHY status inputs may change asynchronously
// Lane n is reset by i_rst or i_lane_rst[n], both
// sampled on clk
// Lanes sequence independently, no bonding
//////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

`include "rxrst_cfg.svh"

module rxrst_top (
    input  wire                           clk,
    input  wire                           i_rst,
    input  wire  [`RXRST_NUM_LANES-1:0]   i_lane_rst,   // Per-lane software reset
    input  wire  [`RXRST_NUM_LANES-1:0]   i_pll_lock,
    input  wire  [`RXRST_NUM_LANES-1:0]   i_sigdet,
    input  wire  [`RXRST_NUM_LANES-1:0]   i_cdr_ready,
    input  wire  [`RXRST_NUM_LANES-1:0]   i_word_sync,
    output logic [`RXRST_NUM_LANES-1:0]   o_lane_pd,
    output logic [`RXRST_NUM_LANES-1:0]   o_pma_rst,
    output logic [`RXRST_NUM_LANES-1:0]   o_pcs_rst,
    output logic [`RXRST_NUM_LANES-1:0]   o_lane_done
);

    logic [`RXRST_NUM_LANES-1:0] lane_rst;

    assign lane_rst = {`RXRST_NUM_LANES{i_rst}} | i_lane_rst;

    for (genvar n = 0; n < `RXRST_NUM_LANES; n++) begin : g_lane

        rx_status_if status_if ();  // Conditioner to FSM link of this lane

        rx_status_cond status_cond (
            .clk          (clk),
            .i_rst        (lane_rst[n]),
            .i_pll_lock   (i_pll_lock[n]),
            .i_sigdet     (i_sigdet[n]),
            .i_cdr_ready  (i_cdr_ready[n]),
            .i_word_sync  (i_word_sync[n]),
            .o_status     (status_if.producer)
        );

        rxlane_rst_fsm rxlane_fsm (
            .clk          (clk),
            .i_rst        (lane_rst[n]),
            .i_status     (status_if.consumer),
            .o_lane_pd    (o_lane_pd[n]),
            .o_pma_rst    (o_pma_rst[n]),
            .o_pcs_rst    (o_pcs_rst[n]),
            .o_lane_done  (o_lane_done[n])
        );

    end

endmodule

`default_nettype wire
